//--- sim.f
source/soc_pkg.sv
source/apb_if.sv
source/apb_decoder.sv
source/apb_ram.sv
source/apb_gpio.sv
source/apb_timer.sv
source/soc_periph_top.sv
verification/tb_soc.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir

verilator --binary --timing --assert \
    --top-module tb_soc \
    -f sim.f \
    -o tb_soc_sim

./obj_dir/tb_soc_sim

//--- verification/tb_soc.sv
module tb_soc;

    timeunit 1ns;
    timeprecision 1ps;

    import soc_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic              clk;
    logic              arst_n;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [STRB_W-1:0] pstrb;
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
    logic [DATA_W-1:0] gpio_out;
    logic              timer_irq;

    int seed;
    int cycle_count;

    soc_periph_top i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .gpio_out  (gpio_out),
        .timer_irq (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ============================================================
    // Reporting and reference helpers
    // ============================================================
    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            fail_run($sformatf("Fail at %0t: %s expected %h, got %h", $time, name, exp, act));
        end
    endtask

    // Byte lanes with a strobe bit take the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] data,
                                                input logic [3:0] strb);
        logic [31:0] result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[8*b +: 8] = data[8*b +: 8];
            end
        end
        return result;
    endfunction

    // ============================================================
    // APB requester
    // ============================================================
    task automatic bus_transfer(input logic write, input logic [31:0] addr,
                                input logic [31:0] data, input logic [3:0] strb,
                                output logic [31:0] rdata, output logic err,
                                output int cycles);
        bit done;
        @(posedge clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        pstrb   = strb;
        cycles  = 1;
        @(posedge clk);
        #2;
        penable = 1'b1;
        done    = 1'b0;
        // Response is sampled mid-cycle, the transfer ends at the next edge
        while (!done) begin
            cycles++;
            @(negedge clk);
            if (pready) begin
                rdata = prdata;
                err   = pslverr;
                done  = 1'b1;
            end
            @(posedge clk);
        end
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [31:0] rdata,
                             output logic err, output int cycles);
        bus_transfer(1'b1, addr, data, strb, rdata, err, cycles);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] rdata,
                            output logic err, output int cycles);
        bus_transfer(1'b0, addr, 32'h0, 4'h0, rdata, err, cycles);
    endtask

    // ============================================================
    // Tests
    // ============================================================
    task automatic reset_state();
        logic [31:0] rdata;
        logic err;
        int cycles;
        check_value("gpio_out", 32'h0, gpio_out);
        check_value("timer_irq", 32'h0, 32'(timer_irq));
        apb_read(GPIO_BASE + 32'(GPIO_OUT), rdata, err, cycles);
        check_value("prdata", 32'h0, rdata);
        check_value("pslverr", 32'h0, 32'(err));
        apb_read(TIMER_BASE + 32'(TIMER_CTRL), rdata, err, cycles);
        check_value("prdata", 32'h0, rdata);
        check_value("pslverr", 32'h0, 32'(err));
        apb_read(TIMER_BASE + 32'(TIMER_STATUS), rdata, err, cycles);
        check_value("prdata", 32'h0, rdata);
        check_value("pslverr", 32'h0, 32'(err));
    endtask

    task automatic ram_rw();
        logic [31:0] model [RAM_WORDS];
        logic [9:0]  idx [16];
        logic [31:0] data;
        logic [31:0] rdata;
        logic [3:0]  strb;
        logic [1:0]  lane;
        logic err;
        int cycles;
        for (int i = 0; i < 16; i++) begin
            idx[i] = 10'($unsigned($random(seed)) % RAM_WORDS);
            data   = $random(seed);
            apb_write(RAM_BASE + {20'b0, idx[i], 2'b00}, data, 4'hF, rdata, err, cycles);
            check_value("pslverr", 32'h0, 32'(err));
            model[idx[i]] = data;
        end
        // One byte per word in a random lane
        for (int i = 0; i < 16; i++) begin
            lane = 2'($unsigned($random(seed)) % 4);
            strb = 4'b0001 << lane;
            data = $random(seed);
            apb_write(RAM_BASE + {20'b0, idx[i], 2'b00}, data, strb, rdata, err, cycles);
            check_value("pslverr", 32'h0, 32'(err));
            model[idx[i]] = merge_bytes(model[idx[i]], data, strb);
        end
        for (int i = 0; i < 16; i++) begin
            apb_read(RAM_BASE + {20'b0, idx[i], 2'b00}, rdata, err, cycles);
            check_value("prdata", model[idx[i]], rdata);
            check_value("pslverr", 32'h0, 32'(err));
            check_value("read cycles", 32'd3, 32'(cycles));
        end
    endtask

    task automatic gpio_check(input logic [31:0] exp);
        logic [31:0] rdata;
        logic err;
        int cycles;
        check_value("gpio_out", exp, gpio_out);
        apb_read(GPIO_BASE + 32'(GPIO_OUT), rdata, err, cycles);
        check_value("prdata", exp, rdata);
        check_value("pslverr", 32'h0, 32'(err));
    endtask

    task automatic gpio_ops();
        logic [31:0] model;
        logic [31:0] rdata;
        logic err;
        int cycles;
        model = 32'h0;
        apb_write(GPIO_BASE + 32'(GPIO_OUT), 32'hA5A5_5A5A, 4'b0101, rdata, err, cycles);
        model = merge_bytes(model, 32'hA5A5_5A5A, 4'b0101);
        gpio_check(model);
        // SET and CLR ignore the strobe
        apb_write(GPIO_BASE + 32'(GPIO_SET), 32'h0F00_F00F, 4'b0000, rdata, err, cycles);
        model = model | 32'h0F00_F00F;
        gpio_check(model);
        apb_write(GPIO_BASE + 32'(GPIO_CLR), 32'h00A5_00FF, 4'b0000, rdata, err, cycles);
        model = model & ~32'h00A5_00FF;
        gpio_check(model);
    endtask

    task automatic unmapped_access();
        logic [31:0] gpio_before;
        logic [31:0] rdata;
        logic err;
        int cycles;
        gpio_before = gpio_out;
        apb_read(32'h2000_0000, rdata, err, cycles);
        check_value("pslverr", 32'h1, 32'(err));
        check_value("prdata", 32'h0, rdata);
        apb_write(32'h2000_0000, 32'hFFFF_FFFF, 4'hF, rdata, err, cycles);
        check_value("pslverr", 32'h1, 32'(err));
        check_value("prdata", 32'h0, rdata);
        check_value("gpio_out", gpio_before, gpio_out);
    endtask

    task automatic timer_irq_flow();
        logic [31:0] rdata;
        logic err;
        int cycles;
        int rise;
        int fall;
        apb_write(TIMER_BASE + 32'(TIMER_LOAD), 32'd20, 4'hF, rdata, err, cycles);
        apb_write(TIMER_BASE + 32'(TIMER_CTRL), 32'h3, 4'hF, rdata, err, cycles);
        rise = 0;
        for (int k = 1; k <= 22 && rise == 0; k++) begin
            @(posedge clk);
            @(negedge clk);
            if (timer_irq) rise = k;
        end
        assert (rise >= 20) else begin
            fail_run($sformatf("timer_irq rose %0d cycles after the CTRL write, not 20 to 22",
                               rise));
        end

        apb_write(TIMER_BASE + 32'(TIMER_STATUS), 32'h1, 4'hF, rdata, err, cycles);
        fall = 0;
        for (int k = 1; k <= 2 && fall == 0; k++) begin
            @(posedge clk);
            @(negedge clk);
            if (!timer_irq) fall = k;
        end
        assert (fall != 0) else begin
            fail_run("timer_irq did not fall within 2 cycles of the STATUS clear");
        end
        apb_read(TIMER_BASE + 32'(TIMER_STATUS), rdata, err, cycles);
        check_value("status pending", 32'h0, rdata);

        // Counting on with the interrupt masked
        apb_write(TIMER_BASE + 32'(TIMER_CTRL), 32'h1, 4'hF, rdata, err, cycles);
        rdata = 32'h0;
        for (int n = 0; n < 30 && rdata[0] == 1'b0; n++) begin
            apb_read(TIMER_BASE + 32'(TIMER_STATUS), rdata, err, cycles);
            check_value("timer_irq", 32'h0, 32'(timer_irq));
        end
        check_value("status pending", 32'h1, rdata);
        check_value("timer_irq", 32'h0, 32'(timer_irq));

        apb_write(TIMER_BASE + 32'(TIMER_COUNT), 32'h5, 4'hF, rdata, err, cycles);
        check_value("pslverr", 32'h1, 32'(err));
    endtask

    // ============================================================
    // Sequence and timeout
    // ============================================================
    initial begin
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        fail_run("Timeout: the tests did not finish within the cycle limit");
    end

    initial begin
        seed    = 39;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        pstrb   = '0;
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;

        reset_state();
        ram_rw();
        gpio_ops();
        unmapped_access();
        timer_irq_flow();

        $display("All tests passed");
        $finish;
    end

endmodule

//--- source/soc_periph_top.sv
module soc_periph_top (
    input  logic                        clk,
    input  logic                        arst_n,

    // APB requester
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [soc_pkg::ADDR_W-1:0]  paddr,
    input  logic [soc_pkg::DATA_W-1:0]  pwdata,
    input  logic [soc_pkg::STRB_W-1:0]  pstrb,
    output logic [soc_pkg::DATA_W-1:0]  prdata,
    output logic                        pready,
    output logic                        pslverr,

    // Peripheral outputs
    output logic [soc_pkg::DATA_W-1:0]  gpio_out,
    output logic                        timer_irq
);

    apb_if ram_bus ();
    apb_if gpio_bus ();
    apb_if timer_bus ();

    // ============================================================
    // Interconnect
    // ============================================================
    apb_decoder decoder_inst (
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .pstrb     (pstrb),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .ram_bus   (ram_bus.requester),
        .gpio_bus  (gpio_bus.requester),
        .timer_bus (timer_bus.requester)
    );

    // ============================================================
    // Completers
    // ============================================================
    apb_ram ram_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (ram_bus.completer)
    );

    apb_gpio gpio_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .bus      (gpio_bus.completer),
        .gpio_out (gpio_out)
    );

    apb_timer timer_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .bus       (timer_bus.completer),
        .timer_irq (timer_irq)
    );

endmodule

//--- source/apb_timer.sv
module apb_timer (
    input  logic      clk,
    input  logic      arst_n,
    apb_if.completer  bus,
    output logic      timer_irq
);

    import soc_pkg::*;

    logic [1:0]        ctrl_q;
    logic [DATA_W-1:0] load_q;
    logic [DATA_W-1:0] count_q;
    logic              pending_q;
    logic              irq_q;

    logic [DATA_W-1:0] wmask;
    logic              access;
    logic              wr_access;
    logic              ctrl_wr;
    logic              load_wr;
    logic              status_wr;
    logic              known;
    logic              irq_en_d;
    logic              expire;

    assign access    = bus.psel && bus.penable;
    assign wr_access = access && bus.pwrite;
    assign wmask     = strb_to_mask(bus.pstrb);

    assign ctrl_wr   = wr_access && (bus.paddr == TIMER_CTRL) && bus.pstrb[0];
    assign load_wr   = wr_access && (bus.paddr == TIMER_LOAD);
    assign status_wr = wr_access && (bus.paddr == TIMER_STATUS) && bus.pstrb[0];

    // Counter hits one while running
    assign expire    = ctrl_q[CTRL_EN_BIT] && (count_q == 1);

    // Next interrupt enable, so the output drops together with it
    assign irq_en_d  = ctrl_wr ? bus.pwdata[CTRL_IRQ_EN_BIT] : ctrl_q[CTRL_IRQ_EN_BIT];

    // ============================================================
    // Registers and counter
    // ============================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_q    <= '0;
            load_q    <= '0;
            count_q   <= '0;
            pending_q <= 1'b0;
            irq_q     <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                ctrl_q <= bus.pwdata[1:0];
            end

            if (load_wr) begin
                load_q  <= (load_q & ~wmask) | (bus.pwdata & wmask);
                count_q <= (load_q & ~wmask) | (bus.pwdata & wmask);
            end else if (expire) begin
                count_q <= load_q;
            end else if (ctrl_q[CTRL_EN_BIT] && count_q != '0) begin
                count_q <= count_q - 1;
            end

            // A new expiry wins over a clear in the same cycle
            if (expire) begin
                pending_q <= 1'b1;
            end else if (status_wr && bus.pwdata[0]) begin
                pending_q <= 1'b0;
            end

            irq_q <= pending_q && irq_en_d;
        end
    end

    // ============================================================
    // Read data and response
    // ============================================================
    always_comb begin
        known      = 1'b1;
        bus.prdata = '0;
        case (bus.paddr)
            TIMER_CTRL:   bus.prdata = {{(DATA_W-2){1'b0}}, ctrl_q};
            TIMER_LOAD:   bus.prdata = load_q;
            TIMER_COUNT:  bus.prdata = count_q;
            TIMER_STATUS: bus.prdata = {{(DATA_W-1){1'b0}}, pending_q};
            default:      known = 1'b0;
        endcase
    end

    // COUNT is read only
    assign bus.pready  = access;
    assign bus.pslverr = access && (!known || (bus.pwrite && bus.paddr == TIMER_COUNT));
    assign timer_irq   = irq_q;

endmodule

//--- source/apb_gpio.sv
module apb_gpio (
    input  logic                        clk,
    input  logic                        arst_n,
    apb_if.completer                    bus,
    output logic [soc_pkg::DATA_W-1:0]  gpio_out
);

    import soc_pkg::*;

    logic [DATA_W-1:0] gpio_q;
    logic [DATA_W-1:0] wmask;
    logic access;
    logic known;

    assign access = bus.psel && bus.penable;
    assign wmask  = strb_to_mask(bus.pstrb);

    always_comb begin
        case (bus.paddr)
            GPIO_OUT, GPIO_SET, GPIO_CLR: known = 1'b1;
            default:                      known = 1'b0;
        endcase
    end

    // SET and CLR act on whole words
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gpio_q <= '0;
        end else if (access && bus.pwrite) begin
            case (bus.paddr)
                GPIO_OUT: gpio_q <= (gpio_q & ~wmask) | (bus.pwdata & wmask);
                GPIO_SET: gpio_q <= gpio_q | bus.pwdata;
                GPIO_CLR: gpio_q <= gpio_q & ~bus.pwdata;
                default:  gpio_q <= gpio_q;
            endcase
        end
    end

    assign gpio_out    = gpio_q;
    assign bus.pready  = access;
    assign bus.pslverr = access && !known;
    assign bus.prdata  = known ? gpio_q : '0;

endmodule

//--- source/apb_ram.sv
module apb_ram (
    input  logic      clk,
    input  logic      arst_n,
    apb_if.completer  bus
);

    import soc_pkg::*;

    logic [DATA_W-1:0] mem [RAM_WORDS];
    logic [DATA_W-1:0] rdata_q;
    logic [DATA_W-1:0] wmask;
    logic [$clog2(RAM_WORDS)-1:0] word_idx;

    ram_state_e state_q;
    ram_state_e state_d;

    logic access;
    logic wr_access;
    logic rd_start;

    assign word_idx  = bus.paddr[2 +: $clog2(RAM_WORDS)];
    assign wmask     = strb_to_mask(bus.pstrb);
    assign access    = bus.psel && bus.penable;
    assign wr_access = access && bus.pwrite;
    assign rd_start  = access && !bus.pwrite && (state_q == RAM_IDLE);

    // ============================================================
    // Storage
    // ============================================================
    always_ff @(posedge clk) begin
        if (wr_access) begin
            mem[word_idx] <= (mem[word_idx] & ~wmask) | (bus.pwdata & wmask);
        end
        if (rd_start) begin
            rdata_q <= mem[word_idx];
        end
    end

    // One wait state on reads
    always_comb begin
        state_d = state_q;
        case (state_q)
            RAM_IDLE: if (rd_start) state_d = RAM_WAIT;
            RAM_WAIT: state_d = RAM_IDLE;
            default:  state_d = RAM_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= RAM_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign bus.pready  = (state_q == RAM_WAIT) || wr_access;
    assign bus.prdata  = rdata_q;
    assign bus.pslverr = 1'b0;

    ready_in_access: assert property (@(posedge clk) disable iff (!arst_n)
        bus.pready |-> bus.psel && bus.penable);

endmodule

//--- source/apb_decoder.sv
module apb_decoder (
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [soc_pkg::ADDR_W-1:0]  paddr,
    input  logic [soc_pkg::DATA_W-1:0]  pwdata,
    input  logic [soc_pkg::STRB_W-1:0]  pstrb,
    output logic [soc_pkg::DATA_W-1:0]  prdata,
    output logic                        pready,
    output logic                        pslverr,

    apb_if.requester                    ram_bus,
    apb_if.requester                    gpio_bus,
    apb_if.requester                    timer_bus
);

    import soc_pkg::*;

    region_e region;

    // ============================================================
    // Region decode on the upper address bits
    // ============================================================
    always_comb begin
        if (paddr[ADDR_W-1:OFFS_W] == RAM_BASE[ADDR_W-1:OFFS_W]) begin
            region = REGION_RAM;
        end else if (paddr[ADDR_W-1:OFFS_W] == GPIO_BASE[ADDR_W-1:OFFS_W]) begin
            region = REGION_GPIO;
        end else if (paddr[ADDR_W-1:OFFS_W] == TIMER_BASE[ADDR_W-1:OFFS_W]) begin
            region = REGION_TIMER;
        end else begin
            region = REGION_NONE;
        end
    end

    // Only the selected completer sees psel
    assign ram_bus.psel   = psel && (region == REGION_RAM);
    assign gpio_bus.psel  = psel && (region == REGION_GPIO);
    assign timer_bus.psel = psel && (region == REGION_TIMER);

    assign ram_bus.penable   = penable;
    assign ram_bus.pwrite    = pwrite;
    assign ram_bus.paddr     = paddr[OFFS_W-1:0];
    assign ram_bus.pwdata    = pwdata;
    assign ram_bus.pstrb     = pstrb;

    assign gpio_bus.penable  = penable;
    assign gpio_bus.pwrite   = pwrite;
    assign gpio_bus.paddr    = paddr[OFFS_W-1:0];
    assign gpio_bus.pwdata   = pwdata;
    assign gpio_bus.pstrb    = pstrb;

    assign timer_bus.penable = penable;
    assign timer_bus.pwrite  = pwrite;
    assign timer_bus.paddr   = paddr[OFFS_W-1:0];
    assign timer_bus.pwdata  = pwdata;
    assign timer_bus.pstrb   = pstrb;

    // ============================================================
    // Response mux
    // ============================================================
    always_comb begin
        case (region)
            REGION_RAM: begin
                prdata  = ram_bus.prdata;
                pready  = ram_bus.pready;
                pslverr = ram_bus.pslverr;
            end
            REGION_GPIO: begin
                prdata  = gpio_bus.prdata;
                pready  = gpio_bus.pready;
                pslverr = gpio_bus.pslverr;
            end
            REGION_TIMER: begin
                prdata  = timer_bus.prdata;
                pready  = timer_bus.pready;
                pslverr = timer_bus.pslverr;
            end
            default: begin
                // Unmapped, error in the first access cycle
                prdata  = '0;
                pready  = psel && penable;
                pslverr = psel && penable;
            end
        endcase
    end

    always_comb begin
        assert final (psel || !penable)
            else $error("penable high without psel");
    end

endmodule

//--- source/apb_if.sv
interface apb_if;

    import soc_pkg::*;

    // Requester side
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [OFFS_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
    logic [STRB_W-1:0] pstrb;

    // Completer side
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;

    modport requester (
        output psel, penable, pwrite, paddr, pwdata, pstrb,
        input  prdata, pready, pslverr
    );

    modport completer (
        input  psel, penable, pwrite, paddr, pwdata, pstrb,
        output prdata, pready, pslverr
    );

endinterface

//--- source/soc_pkg.sv
package soc_pkg;

    // ============================================================
    // Widths and memory map
    // ============================================================
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned STRB_W = DATA_W / 8;
    localparam int unsigned OFFS_W = 12;

    localparam logic [ADDR_W-1:0] RAM_BASE   = 32'h0000_0000;
    localparam logic [ADDR_W-1:0] GPIO_BASE  = 32'h4000_0000;
    localparam logic [ADDR_W-1:0] TIMER_BASE = 32'h4000_1000;

    localparam int unsigned RAM_WORDS = 1024;

    // Timer CTRL bits
    localparam int unsigned CTRL_EN_BIT     = 0;
    localparam int unsigned CTRL_IRQ_EN_BIT = 1;

    // ============================================================
    // Enums
    // ============================================================
    typedef enum logic [1:0] {
        REGION_RAM,
        REGION_GPIO,
        REGION_TIMER,
        REGION_NONE
    } region_e;

    typedef enum logic [OFFS_W-1:0] {
        GPIO_OUT = 12'h000,
        GPIO_SET = 12'h004,
        GPIO_CLR = 12'h008
    } gpio_reg_e;

    typedef enum logic [OFFS_W-1:0] {
        TIMER_CTRL   = 12'h000,
        TIMER_LOAD   = 12'h004,
        TIMER_COUNT  = 12'h008,
        TIMER_STATUS = 12'h00C
    } timer_reg_e;

    typedef enum logic {
        RAM_IDLE,
        RAM_WAIT
    } ram_state_e;

    // Byte strobe expanded to a bit mask
    function automatic logic [DATA_W-1:0] strb_to_mask(input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] mask;
        for (int i = 0; i < STRB_W; i++) begin
            mask[8*i +: 8] = {8{strb[i]}};
        end
        return mask;
    endfunction

endpackage
